// ==== list.f ====
source/arbiter_pkg.sv
source/arbiter_control.sv
source/arbiter_datapath.sv
source/cache_arbiter.sv
test/pmem_model.sv
test/cache_arbiter_props.sv
test/cache_arbiter_tb.sv

// ==== Bender.yml ====
package:
  name: cache_arbiter

sources:
  # design
  - files:
      - source/arbiter_pkg.sv
      - source/arbiter_control.sv
      - source/arbiter_datapath.sv
      - source/cache_arbiter.sv

  # simulation only
  - target: test
    files:
      - test/pmem_model.sv
      - test/cache_arbiter_props.sv
      - test/cache_arbiter_tb.sv

// ==== test/cache_arbiter_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_arbiter_tb
	import arbiter_pkg::*;
();

	localparam int addr_bits = ADDR_BITS_DEF;
	localparam int line_bits = LINE_BITS_DEF;
	localparam int lines = 16;
	localparam int offset_bits = $clog2(line_bits / 8);
	localparam int index_bits = $clog2(lines);
	localparam int random_per_cache = 100;
	localparam int planned_requests = 5 + 2 * random_per_cache;
	localparam int timeout_cycles = 20 * planned_requests + 100;

	logic clk;
	logic arst_n;
	logic icache_read;
	logic [addr_bits-1:0] icache_address;
	logic [line_bits-1:0] icache_rdata;
	logic icache_resp;
	logic dcache_read;
	logic dcache_write;
	logic [addr_bits-1:0] dcache_address;
	logic [line_bits-1:0] dcache_wdata;
	logic [line_bits-1:0] dcache_rdata;
	logic dcache_resp;
	logic pmem_read;
	logic pmem_write;
	logic [addr_bits-1:0] pmem_address;
	logic [line_bits-1:0] pmem_wdata;
	logic [line_bits-1:0] pmem_rdata;
	logic pmem_resp;

	logic [line_bits-1:0] shadow [lines];
	logic [line_bits-1:0] icache_exp_q [$];
	logic [line_bits-1:0] dcache_exp_q [$];
	logic dcache_wr_q [$];
	logic [31:0] rng_state = 32'he1879b21;
	int cycle = 0;
	int icache_resp_cycle;
	int dcache_resp_cycle;

	// stimulus for the random phase is drawn before the drivers start.
	logic [addr_bits-1:0] i_addr [random_per_cache];
	int i_gap [random_per_cache];
	logic d_write [random_per_cache];
	logic [addr_bits-1:0] d_addr [random_per_cache];
	logic [line_bits-1:0] d_data [random_per_cache];
	int d_gap [random_per_cache];

	cache_arbiter #(
		.addr_bits (addr_bits),
		.line_bits (line_bits)
	) dut0
	(
		.clk            (clk),
		.arst_n         (arst_n),
		.icache_read    (icache_read),
		.icache_address (icache_address),
		.icache_rdata   (icache_rdata),
		.icache_resp    (icache_resp),
		.dcache_read    (dcache_read),
		.dcache_write   (dcache_write),
		.dcache_address (dcache_address),
		.dcache_wdata   (dcache_wdata),
		.dcache_rdata   (dcache_rdata),
		.dcache_resp    (dcache_resp),
		.pmem_read      (pmem_read),
		.pmem_write     (pmem_write),
		.pmem_address   (pmem_address),
		.pmem_wdata     (pmem_wdata),
		.pmem_rdata     (pmem_rdata),
		.pmem_resp      (pmem_resp)
	);

	pmem_model #(
		.addr_bits (addr_bits),
		.line_bits (line_bits),
		.lines     (lines),
		.delay     (3)
	) pmem0
	(
		.clk          (clk),
		.arst_n       (arst_n),
		.pmem_read    (pmem_read),
		.pmem_write   (pmem_write),
		.pmem_address (pmem_address),
		.pmem_wdata   (pmem_wdata),
		.pmem_rdata   (pmem_rdata),
		.pmem_resp    (pmem_resp)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] rand32();
		rng_state = lcg_next(rng_state);
		return rng_state;
	endfunction

	function automatic logic [line_bits-1:0] random_line();
		logic [line_bits-1:0] line;
		for (int w = 0; w < line_bits / 32; w++)
		begin
			line[w*32 +: 32] = rand32();
		end
		return line;
	endfunction

	function automatic logic [addr_bits-1:0] line_address(input int idx);
		return addr_bits'(idx) << offset_bits;
	endfunction

	// power-up content of memory with each word holding its line index and word number.
	function automatic logic [line_bits-1:0] fill_line(input int idx);
		logic [line_bits-1:0] line;
		for (int w = 0; w < line_bits / 32; w++)
		begin
			line[w*32 +: 32] = 32'ha500_0000 | (idx << 8) | w;
		end
		return line;
	endfunction

	// expected line for a request.
	// a write lands in the shadow when it is issued.
	function automatic logic [line_bits-1:0] shadow_access(input logic write,
		input logic [addr_bits-1:0] address, input logic [line_bits-1:0] wdata);
		int idx;
		idx = address[offset_bits +: index_bits];
		if (write)
		begin
			shadow[idx] = wdata;
		end
		return shadow[idx];
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check(input string name, input logic [line_bits-1:0] got,
		input logic [line_bits-1:0] expected);
		if (got !== expected)
		begin
			fail_run($sformatf("ERR %0t %s: got %0h, expected %0h",
				$time, name, got, expected));
		end
	endtask

	// the icache reads the shadow on the edge before a dcache issued in the same cycle.
	task automatic icache_request(input logic [addr_bits-1:0] address);
		@(posedge clk);
		icache_exp_q.push_back(shadow_access(1'b0, address, '0));
		#1;
		icache_address = address;
		icache_read = 1'b1;
		do @(negedge clk); while (!icache_resp);
		icache_resp_cycle = cycle;
		@(posedge clk);
		#1;
		icache_read = 1'b0;
	endtask

	task automatic dcache_request(input logic write, input logic [addr_bits-1:0] address,
		input logic [line_bits-1:0] wdata);
		@(posedge clk);
		#1;
		dcache_exp_q.push_back(shadow_access(write, address, wdata));
		dcache_wr_q.push_back(write);
		dcache_address = address;
		dcache_wdata = wdata;
		dcache_read = !write;
		dcache_write = write;
		do @(negedge clk); while (!dcache_resp);
		dcache_resp_cycle = cycle;
		@(posedge clk);
		#1;
		dcache_read = 1'b0;
		dcache_write = 1'b0;
	endtask

	task automatic icache_random();
		for (int n = 0; n < random_per_cache; n++)
		begin
			repeat (i_gap[n]) @(posedge clk);
			icache_request(i_addr[n]);
		end
	endtask

	task automatic dcache_random();
		for (int n = 0; n < random_per_cache; n++)
		begin
			repeat (d_gap[n]) @(posedge clk);
			dcache_request(d_write[n], d_addr[n], d_data[n]);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#2;
			clk = ~clk;
		end
	end

	always @(posedge clk)
	begin
		cycle++;
		if (cycle >= timeout_cycles)
		begin
			fail_run($sformatf("timeout: requests still open after %0d cycles", cycle));
		end
	end

	// every resp must match the oldest open request of its own cache.
	always @(negedge clk)
	begin
		logic was_write;
		logic [line_bits-1:0] expected;
		if (arst_n && icache_resp)
		begin
			if (icache_exp_q.size() == 0)
			begin
				fail_run("icache_resp pulsed while no icache request was open");
			end
			else
			begin
				check("icache_rdata", icache_rdata, icache_exp_q.pop_front());
			end
		end
		if (arst_n && dcache_resp)
		begin
			if (dcache_exp_q.size() == 0)
			begin
				fail_run("dcache_resp pulsed while no dcache request was open");
			end
			else
			begin
				was_write = dcache_wr_q.pop_front();
				expected = dcache_exp_q.pop_front();
				if (!was_write)
				begin
					check("dcache_rdata", dcache_rdata, expected);
				end
			end
		end
		if (dut0.props0.fail_count != 0)
		begin
			fail_run("a bound assertion failed");
		end
	end

	initial
	begin
		arst_n = 1'b1;
		icache_read = 1'b0;
		icache_address = '0;
		dcache_read = 1'b0;
		dcache_write = 1'b0;
		dcache_address = '0;
		dcache_wdata = '0;
		for (int i = 0; i < lines; i++)
		begin
			shadow[i] = fill_line(i);
		end
		for (int n = 0; n < random_per_cache; n++)
		begin
			i_addr[n] = line_address((rand32() >> 16) % lines);
			i_gap[n] = rand32() >> 30;
			d_write[n] = rand32() >> 31;
			d_addr[n] = line_address((rand32() >> 16) % lines);
			d_data[n] = random_line();
			d_gap[n] = rand32() >> 30;
		end
		#1;
		arst_n = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// quiet after reset.
		repeat (10)
		begin
			@(negedge clk);
			check("pmem_read", pmem_read, 1'b0);
			check("pmem_write", pmem_write, 1'b0);
			check("icache_resp", icache_resp, 1'b0);
			check("dcache_resp", dcache_resp, 1'b0);
		end

		icache_request(line_address(3));
		dcache_request(1'b1, line_address(5), random_line());
		dcache_request(1'b0, line_address(5), '0);

		// same-cycle tie where the icache goes first.
		fork
			icache_request(line_address(7));
			dcache_request(1'b0, line_address(9), '0);
		join
		check("icache_resp before dcache_resp", icache_resp_cycle < dcache_resp_cycle, 1'b1);

		fork
			icache_random();
			dcache_random();
		join

		repeat (4) @(negedge clk);
		if (dut0.props0.fail_count == 0)
		begin
			$display("Test completed successfully");
			$finish;
		end
		else
		begin
			fail_run("one or more bound assertions failed");
		end
	end

endmodule : cache_arbiter_tb

`default_nettype wire

// ==== test/cache_arbiter_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_arbiter_props
	import arbiter_pkg::*;
(
	input wire logic       clk,
	input wire logic       arst_n,
	input wire logic       pmem_read,
	input wire logic       pmem_write,
	input wire logic       icache_resp,
	input wire logic       dcache_resp,
	input wire arb_state_t state
);

	// number of failed assertions that the testbench watches.
	int unsigned fail_count = 0;

	property strobes_exclusive;
		@(posedge clk) disable iff (!arst_n) !(pmem_read && pmem_write);
	endproperty

	// a resp reaches only the cache that owns the port and never both at once.
	property resp_exclusive;
		@(posedge clk) disable iff (!arst_n)
			(!icache_resp || state == service_icache)
			&& (!dcache_resp || state == service_dcache);
	endproperty

	// the controller must sit in idle for the whole reset.
	property idle_in_reset;
		@(posedge clk) !arst_n |-> (state == idle);
	endproperty

	strobes_check: assert property (strobes_exclusive)
	else
	begin
		$error("pmem_read and pmem_write are high together");
		fail_count++;
	end

	resp_check: assert property (resp_exclusive)
	else
	begin
		$error("a resp reached a cache that does not own the port");
		fail_count++;
	end

	reset_check: assert property (idle_in_reset)
	else
	begin
		$error("controller state is not idle during reset");
		fail_count++;
	end

endmodule : cache_arbiter_props

bind cache_arbiter cache_arbiter_props props0
(
	.clk         (clk),
	.arst_n      (arst_n),
	.pmem_read   (pmem_read),
	.pmem_write  (pmem_write),
	.icache_resp (icache_resp),
	.dcache_resp (dcache_resp),
	.state       (control.state)
);

`default_nettype wire

// ==== test/pmem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmem_model #(
	parameter int addr_bits = 32,
	parameter int line_bits = 256,
	parameter int lines = 16,
	parameter int delay = 3
)
(
	input  wire logic                 clk,
	input  wire logic                 arst_n,
	input  wire logic                 pmem_read,
	input  wire logic                 pmem_write,
	input  wire logic [addr_bits-1:0] pmem_address,
	input  wire logic [line_bits-1:0] pmem_wdata,
	output logic      [line_bits-1:0] pmem_rdata,
	output logic                      pmem_resp
);

	localparam int offset_bits = $clog2(line_bits / 8);
	localparam int index_bits = $clog2(lines);

	logic [line_bits-1:0] mem [lines];
	logic [index_bits-1:0] index;
	int count;

	assign index = pmem_address[offset_bits +: index_bits];

	// each 32-bit word holds its line index and its word number.
	initial
	begin
		for (int i = 0; i < lines; i++)
		begin
			for (int w = 0; w < line_bits / 32; w++)
			begin
				mem[i][w*32 +: 32] = 32'ha500_0000 | (i << 8) | w;
			end
		end
	end

	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			count <= 0;
			pmem_resp <= 1'b0;
			pmem_rdata <= '0;
		end
		else
		begin
			pmem_resp <= 1'b0;
			// a strobe still high in the resp cycle belongs to the finished transfer.
			if (!pmem_resp && (pmem_read || pmem_write))
			begin
				if (count == delay - 1)
				begin
					count <= 0;
					pmem_resp <= 1'b1;
					if (pmem_write)
					begin
						mem[index] <= pmem_wdata;
					end
					else
					begin
						pmem_rdata <= mem[index];
					end
				end
				else
				begin
					count <= count + 1;
				end
			end
		end
	end

endmodule : pmem_model

`default_nettype wire

// ==== source/cache_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_arbiter
	import arbiter_pkg::*;
#(
	parameter int addr_bits = ADDR_BITS_DEF,
	parameter int line_bits = LINE_BITS_DEF
)
(
	input  wire logic                 clk,
	input  wire logic                 arst_n,

	// instruction cache.
	input  wire logic                 icache_read,
	input  wire logic [addr_bits-1:0] icache_address,
	output wire logic [line_bits-1:0] icache_rdata,
	output wire logic                 icache_resp,

	// data cache.
	input  wire logic                 dcache_read,
	input  wire logic                 dcache_write,
	input  wire logic [addr_bits-1:0] dcache_address,
	input  wire logic [line_bits-1:0] dcache_wdata,
	output wire logic [line_bits-1:0] dcache_rdata,
	output wire logic                 dcache_resp,

	// physical memory.
	output wire logic                 pmem_read,
	output wire logic                 pmem_write,
	output wire logic [addr_bits-1:0] pmem_address,
	output wire logic [line_bits-1:0] pmem_wdata,
	input  wire logic [line_bits-1:0] pmem_rdata,
	input  wire logic                 pmem_resp
);

	// low selects the icache, high the dcache.
	wire logic cache_sel;

	arbiter_control control
	(
		.clk        (clk),
		.arst_n     (arst_n),
		.iread      (icache_read),
		.dread      (dcache_read),
		.dwrite     (dcache_write),
		.pmem_resp  (pmem_resp),
		.cache_sel  (cache_sel),
		.pmem_read  (pmem_read),
		.pmem_write (pmem_write)
	);

	arbiter_datapath #(
		.addr_bits (addr_bits),
		.line_bits (line_bits)
	) datapath
	(
		.cache_sel      (cache_sel),
		.icache_address (icache_address),
		.dcache_address (dcache_address),
		.dcache_wdata   (dcache_wdata),
		.pmem_rdata     (pmem_rdata),
		.pmem_resp      (pmem_resp),
		.pmem_address   (pmem_address),
		.pmem_wdata     (pmem_wdata),
		.icache_rdata   (icache_rdata),
		.dcache_rdata   (dcache_rdata),
		.icache_resp    (icache_resp),
		.dcache_resp    (dcache_resp)
	);

endmodule : cache_arbiter

`default_nettype wire

// ==== source/arbiter_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module arbiter_datapath
	import arbiter_pkg::*;
#(
	parameter int addr_bits = ADDR_BITS_DEF,
	parameter int line_bits = LINE_BITS_DEF
)
(
	input  wire logic                 cache_sel,
	input  wire logic [addr_bits-1:0] icache_address,
	input  wire logic [addr_bits-1:0] dcache_address,
	input  wire logic [line_bits-1:0] dcache_wdata,
	input  wire logic [line_bits-1:0] pmem_rdata,
	input  wire logic                 pmem_resp,
	output logic      [addr_bits-1:0] pmem_address,
	output logic      [line_bits-1:0] pmem_wdata,
	output logic      [line_bits-1:0] icache_rdata,
	output logic      [line_bits-1:0] dcache_rdata,
	output logic                      icache_resp,
	output logic                      dcache_resp
);

	// address comes from whichever cache owns the port.
	always_comb
	begin
		if (cache_sel)
		begin
			pmem_address = dcache_address;
		end
		else
		begin
			pmem_address = icache_address;
		end
	end

	// only the dcache ever writes.
	assign pmem_wdata = dcache_wdata;

	// read data goes to both caches.
	assign icache_rdata = pmem_rdata;
	assign dcache_rdata = pmem_rdata;

	// resp is steered so that a cache never takes a line that belongs to the other.
	always_comb
	begin
		icache_resp = 1'b0;
		dcache_resp = 1'b0;
		if (cache_sel)
		begin
			dcache_resp = pmem_resp;
		end
		else
		begin
			icache_resp = pmem_resp;
		end
	end

endmodule : arbiter_datapath

`default_nettype wire

// ==== source/arbiter_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module arbiter_control
	import arbiter_pkg::*;
(
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic iread,
	input  wire logic dread,
	input  wire logic dwrite,
	input  wire logic pmem_resp,
	output logic      cache_sel,
	output logic      pmem_read,
	output logic      pmem_write
);

	arb_state_t state;
	arb_state_t next_state;

	// the dcache wants the port for either a read or a write.
	logic dreq;

	// the current owner finishes its transfer this cycle.
	logic done;

	assign dreq = dread | dwrite;
	assign done = pmem_resp;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= idle;
		end
		else
		begin
			state <= next_state;
		end
	end

	// icache wins a tie in idle.
	// on a resp the port passes straight to a waiting cache of the other kind.
	always_comb
	begin
		next_state = state;
		case (state)
			idle:
			begin
				if (iread)
				begin
					next_state = service_icache;
				end
				else if (dreq)
				begin
					next_state = service_dcache;
				end
			end

			service_icache:
			begin
				if (done)
				begin
					if (dreq)
					begin
						next_state = service_dcache;
					end
					else
					begin
						next_state = idle;
					end
				end
			end

			service_dcache:
			begin
				if (done)
				begin
					if (iread)
					begin
						next_state = service_icache;
					end
					else
					begin
						next_state = idle;
					end
				end
			end

			default:
			begin
				next_state = idle;
			end
		endcase
	end

	// outputs are mealy so a request seen in idle reaches memory in the same cycle.
	// the owner keeps cache_sel and its strobe through its resp cycle
	// and the next owner is driven from the following cycle on.
	always_comb
	begin
		cache_sel = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		case (state)
			idle:
			begin
				if (iread)
				begin
					cache_sel = 1'b0;
					pmem_read = 1'b1;
				end
				else if (dreq)
				begin
					cache_sel = 1'b1;
					pmem_read = dread;
					pmem_write = dwrite;
				end
			end

			service_icache:
			begin
				cache_sel = 1'b0;
				pmem_read = 1'b1;
			end

			service_dcache:
			begin
				cache_sel = 1'b1;
				pmem_read = dread;
				pmem_write = dwrite;
			end

			default:
			begin
				cache_sel = 1'b0;
			end
		endcase
	end

endmodule : arbiter_control

`default_nettype wire

// ==== source/arbiter_pkg.sv ====
`default_nettype none

package arbiter_pkg;

	// default physical address width in bits.
	parameter int ADDR_BITS_DEF = 32;

	// one memory transfer moves one cache line of this default width.
	parameter int LINE_BITS_DEF = 256;

	// owner of the physical memory port.
	// idle means no transfer is in flight and no cache is selected.
	typedef enum logic [1:0] {
		idle           = 2'b00,
		service_icache = 2'b01,
		service_dcache = 2'b10
	} arb_state_t;

endpackage : arbiter_pkg

`default_nettype wire
